// ==== dma_pkg.sv ====
package dma_pkg;

	localparam int fsab_addr_w = 31;
	localparam int fsab_data_w = 64;
	localparam int fsab_id_w = 4;
	localparam int fsab_len_w = 7;
	localparam int spam_addr_w = 24;
	localparam int fsab_credits_w = 4;

	localparam logic [fsab_credits_w-1:0] fsab_initial_credits = 4'd4;

	typedef enum logic {
		fsab_read = 1'b0,
		fsab_write = 1'b1
	} fsab_mode_e;

	typedef enum logic {
		fetch_idle = 1'b0,
		fetch_wait = 1'b1
	} fetch_state_e;

	// Request to the system bus, one word per request.
	typedef struct packed {
		logic valid;
		fsab_mode_e mode;
		logic [fsab_id_w-1:0] did;
		logic [fsab_id_w-1:0] subdid;
		logic [fsab_addr_w-1:0] addr;
		logic [fsab_len_w-1:0] len;
	} fsab_req_t;

	typedef struct packed {
		logic valid;
		logic [fsab_id_w-1:0] did;
		logic [fsab_id_w-1:0] subdid;
		logic [fsab_data_w-1:0] data;
	} fsab_resp_t;

	// Register bus command, the device ID shares the bus ID width.
	typedef struct packed {
		logic valid;
		logic r_nw;
		logic [fsab_id_w-1:0] did;
		logic [spam_addr_w-1:0] addr;
	} spam_req_t;

endpackage

// ==== dma_read_fifo.sv ====
module dma_read_fifo #(
	parameter int depth = 128
) (
	input logic clk,
	input logic rst_b,
	input logic push,
	input logic [dma_pkg::fsab_data_w-1:0] wdata,
	input logic pop,
	output logic [dma_pkg::fsab_data_w-1:0] rdata,
	output logic [$clog2(depth+1)-1:0] count,
	output logic full,
	output logic empty
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	logic [dma_pkg::fsab_data_w-1:0] mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head word, valid whenever not empty.
	assign rdata = mem[rd_ptr];
	assign full = (count == cnt_w'(depth));
	assign empty = (count == '0);

	assert property (@(posedge clk) disable iff (!rst_b) !(push && full))
		else $error("FIFO push while full");
	assert property (@(posedge clk) disable iff (!rst_b) !(pop && empty))
		else $error("FIFO pop while empty");

endmodule

// ==== dma_fetch_engine.sv ====
module dma_fetch_engine #(
	parameter logic [dma_pkg::fsab_id_w-1:0] fsab_did = '0,
	parameter logic [dma_pkg::fsab_id_w-1:0] fsab_subdid = '0,
	parameter logic [dma_pkg::fsab_addr_w-1:0] default_addr = '0
) (
	input logic clk,
	input logic rst_b,
	output dma_pkg::fsab_req_t fsab_req,
	input logic fsab_credit,
	input dma_pkg::fsab_resp_t fsab_resp,
	input logic fifo_full,
	output logic fifo_push,
	output logic [dma_pkg::fsab_data_w-1:0] fifo_wdata
);

	dma_pkg::fetch_state_e state;
	logic [dma_pkg::fsab_credits_w-1:0] credits;
	logic [dma_pkg::fsab_addr_w-1:0] next_addr;
	logic start_read;
	logic resp_match;

	// Only one read in flight, so a request waits for the previous response.
	// Held low while in reset.
	assign start_read = rst_b && (state == dma_pkg::fetch_idle) &&
		(credits != '0) && !fifo_full;

	assign resp_match = fsab_resp.valid &&
		(fsab_resp.did == fsab_did) &&
		(fsab_resp.subdid == fsab_subdid);

	always_comb begin
		fsab_req.valid = start_read;
		fsab_req.mode = dma_pkg::fsab_read;
		fsab_req.did = fsab_did;
		fsab_req.subdid = fsab_subdid;
		fsab_req.addr = next_addr;
		fsab_req.len = dma_pkg::fsab_len_w'(1);
	end

	// Data lands in the FIFO on the edge that ends the response cycle.
	assign fifo_push = (state == dma_pkg::fetch_wait) && resp_match;
	assign fifo_wdata = fsab_resp.data;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits <= dma_pkg::fsab_initial_credits;
		end else begin
			credits <= credits
				+ dma_pkg::fsab_credits_w'(fsab_credit)
				- dma_pkg::fsab_credits_w'(start_read);
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state <= dma_pkg::fetch_idle;
			next_addr <= default_addr;
		end else begin
			case (state)
				dma_pkg::fetch_idle: begin
					if (start_read) begin
						state <= dma_pkg::fetch_wait;
					end
				end
				dma_pkg::fetch_wait: begin
					if (resp_match) begin
						state <= dma_pkg::fetch_idle;
						next_addr <= next_addr + dma_pkg::fsab_addr_w'(8);
					end
				end
				default: state <= dma_pkg::fetch_idle;
			endcase
		end
	end

	// The slave never returns more credits than were handed out.
	// A request without a credit would wrap the count past this bound too.
	assert property (@(posedge clk) disable iff (!rst_b)
		credits <= dma_pkg::fsab_initial_credits)
		else $error("FSAB credit count out of range: %0d", credits);

endmodule

// ==== spam_read_port.sv ====
module spam_read_port #(
	parameter logic [dma_pkg::fsab_id_w-1:0] spam_did = '0,
	parameter logic [dma_pkg::spam_addr_w-1:0] spam_addr_pfx = '0,
	parameter logic [dma_pkg::spam_addr_w-1:0] spam_addr_mask = '0
) (
	input logic clk,
	input logic rst_b,
	input dma_pkg::spam_req_t spam_req,
	input logic fifo_empty,
	input logic [dma_pkg::fsab_data_w-1:0] fifo_rdata,
	output logic fifo_pop,
	output logic spam_busy_b,
	output logic [63:0] spam_data
);

	logic read_hit;

	// A read for our ID inside the address window.
	assign read_hit = spam_req.valid && spam_req.r_nw &&
		(spam_req.did == spam_did) &&
		((spam_req.addr & spam_addr_mask) == (spam_addr_pfx & spam_addr_mask));

	assign fifo_pop = read_hit && !fifo_empty;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			spam_busy_b <= 1'b0;
		end else begin
			spam_busy_b <= fifo_pop;
		end
	end

	// Data holds its old value on a miss or an empty FIFO.
	always_ff @(posedge clk) begin
		if (fifo_pop) begin
			spam_data <= fifo_rdata;
		end
	end

endmodule

// ==== dma_read_controller.sv ====
module dma_read_controller #(
	parameter int fifo_depth = 128,
	parameter logic [dma_pkg::fsab_id_w-1:0] fsab_did = '0,
	parameter logic [dma_pkg::fsab_id_w-1:0] fsab_subdid = '0,
	parameter logic [dma_pkg::fsab_id_w-1:0] spam_did = '0,
	parameter logic [dma_pkg::spam_addr_w-1:0] spam_addr_pfx = '0,
	parameter logic [dma_pkg::spam_addr_w-1:0] spam_addr_mask = '0,
	parameter logic [dma_pkg::fsab_addr_w-1:0] default_addr = '0
) (
	input logic clk,
	input logic rst_b,
	output dma_pkg::fsab_req_t fsab_req,
	input logic fsab_credit,
	input dma_pkg::fsab_resp_t fsab_resp,
	input dma_pkg::spam_req_t spam_req,
	output logic spam_busy_b,
	output logic [63:0] spam_data
);

	logic fifo_push;
	logic [dma_pkg::fsab_data_w-1:0] fifo_wdata;
	logic fifo_pop;
	logic [dma_pkg::fsab_data_w-1:0] fifo_rdata;
	logic [$clog2(fifo_depth+1)-1:0] fifo_count;
	logic fifo_full;
	logic fifo_empty;

	dma_fetch_engine #(
		.fsab_did(fsab_did),
		.fsab_subdid(fsab_subdid),
		.default_addr(default_addr)
	) u_fetch (
		.clk(clk),
		.rst_b(rst_b),
		.fsab_req(fsab_req),
		.fsab_credit(fsab_credit),
		.fsab_resp(fsab_resp),
		.fifo_full(fifo_full),
		.fifo_push(fifo_push),
		.fifo_wdata(fifo_wdata)
	);

	dma_read_fifo #(
		.depth(fifo_depth)
	) u_fifo (
		.clk(clk),
		.rst_b(rst_b),
		.push(fifo_push),
		.wdata(fifo_wdata),
		.pop(fifo_pop),
		.rdata(fifo_rdata),
		.count(fifo_count),
		.full(fifo_full),
		.empty(fifo_empty)
	);

	spam_read_port #(
		.spam_did(spam_did),
		.spam_addr_pfx(spam_addr_pfx),
		.spam_addr_mask(spam_addr_mask)
	) u_spam (
		.clk(clk),
		.rst_b(rst_b),
		.spam_req(spam_req),
		.fifo_empty(fifo_empty),
		.fifo_rdata(fifo_rdata),
		.fifo_pop(fifo_pop),
		.spam_busy_b(spam_busy_b),
		.spam_data(spam_data)
	);

	// A read only goes out when its word is sure to find room.
	assert property (@(posedge clk) disable iff (!rst_b)
		fsab_req.valid |-> (fifo_count < fifo_depth))
		else $error("FSAB request with a full FIFO, count %0d", fifo_count);

endmodule

// ==== tb_fsab_memory.sv ====
module tb_fsab_memory #(
	parameter logic [dma_pkg::fsab_id_w-1:0] fsab_did = '0,
	parameter logic [dma_pkg::fsab_id_w-1:0] fsab_subdid = '0,
	parameter logic [dma_pkg::fsab_addr_w-1:0] base_addr = '0,
	parameter int initial_credits = 4
) (
	input logic clk,
	input logic rst_b,
	input dma_pkg::fsab_req_t fsab_req,
	output logic fsab_credit,
	output dma_pkg::fsab_resp_t fsab_resp,
	output logic error,
	output int req_count
);

	localparam int fields = 6;
	localparam int rec_max = 48;
	localparam int hold_after = 10;
	localparam int hold_cycles = 40;

	logic [63:0] stim [fields*rec_max];
	logic [63:0] words [$];
	int credit_due [$];
	int credits_out;
	int countdown;
	int cycle;
	int hold_until;
	int resp_count;
	dma_pkg::fsab_req_t req_seen;
	logic credit_seen;

	task automatic check_field(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
			error = 1'b1;
		end
	endtask

	// Request and credit were sampled on the rising edge that the DUT used.
	task automatic serve_cycle();
		logic [dma_pkg::fsab_addr_w-1:0] want;
		cycle++;
		fsab_resp = '0;
		fsab_credit = 1'b0;
		if (!rst_b) begin
			return;
		end
		if (req_seen.valid) begin
			want = base_addr + dma_pkg::fsab_addr_w'(8 * req_count);
			check_field("fsab_req.addr", 64'(req_seen.addr), 64'(want));
			check_field("fsab_req.mode", 64'(req_seen.mode), 64'(dma_pkg::fsab_read));
			check_field("fsab_req.len", 64'(req_seen.len), 64'(1));
			check_field("fsab_req.did", 64'(req_seen.did), 64'(fsab_did));
			check_field("fsab_req.subdid", 64'(req_seen.subdid), 64'(fsab_subdid));
			assert (credits_out < initial_credits) else begin
				$display("A request went out with all %0d credits in use", initial_credits);
				error = 1'b1;
			end
			credits_out++;
			req_count++;
			countdown = 1 + int'($urandom % 6);
		end
		if (credit_seen) begin
			credits_out--;
		end
		if (countdown > 0) begin
			countdown--;
			if (countdown == 0) begin
				assert (words.size() > 0) else begin
					$display("The bus model ran out of response words");
					error = 1'b1;
				end
				fsab_resp.valid = 1'b1;
				fsab_resp.did = fsab_did;
				fsab_resp.subdid = fsab_subdid;
				fsab_resp.data = (words.size() > 0) ? words.pop_front() : 64'd0;
				credit_due.push_back(cycle + 2);
				resp_count++;
				if (resp_count == hold_after) begin
					hold_until = cycle + hold_cycles;
				end
			end else if ($urandom % 4 == 0) begin
				// Traffic for another device on the shared response bus.
				fsab_resp.valid = 1'b1;
				fsab_resp.did = fsab_did ^ 4'h8;
				fsab_resp.subdid = fsab_subdid;
				fsab_resp.data = 64'hdead_0000_0000_0000 | 64'(cycle);
			end
		end
		if (cycle >= hold_until && credit_due.size() > 0 && credit_due[0] <= cycle) begin
			void'(credit_due.pop_front());
			fsab_credit = 1'b1;
		end
	endtask

	initial begin
		void'($urandom(84));
		$readmemh("dma_stimulus.txt", stim);
		for (int r = 0; r < rec_max; r++) begin
			if (stim[r*fields] == 64'd0) begin
				break;
			end
			if (stim[r*fields] == 64'd1) begin
				words.push_back(stim[r*fields+5]);
			end
		end
		fsab_credit = 1'b0;
		fsab_resp = '0;
		error = 1'b0;
		req_count = 0;
		credits_out = 0;
		countdown = 0;
		cycle = 0;
		hold_until = 0;
		resp_count = 0;
		req_seen = '0;
		credit_seen = 1'b0;
		forever begin
			@(posedge clk);
			req_seen = fsab_req;
			credit_seen = fsab_credit;
			@(negedge clk);
			serve_cycle();
		end
	end

endmodule

// ==== tb_dma_read_controller.sv ====
module tb_dma_read_controller;

	localparam int fifo_depth = 8;
	localparam int fields = 6;
	localparam int rec_max = 48;
	localparam int cycles_per_cmd = 200;
	localparam logic [dma_pkg::fsab_addr_w-1:0] base_addr = 31'h0010_0000;

	logic clk;
	logic rst_b;
	dma_pkg::fsab_req_t fsab_req;
	logic fsab_credit;
	dma_pkg::fsab_resp_t fsab_resp;
	dma_pkg::spam_req_t spam_req;
	logic spam_busy_b;
	logic [63:0] spam_data;
	logic model_error;
	int req_count;
	logic [63:0] stim [fields*rec_max];
	int cmd_total;
	int pop_count;
	logic [63:0] last_data;

	dma_read_controller #(
		.fifo_depth(fifo_depth),
		.fsab_did(4'd2),
		.fsab_subdid(4'd3),
		.spam_did(4'd5),
		.spam_addr_pfx(24'h001000),
		.spam_addr_mask(24'hfff000),
		.default_addr(base_addr)
	) DUT (
		.clk(clk),
		.rst_b(rst_b),
		.fsab_req(fsab_req),
		.fsab_credit(fsab_credit),
		.fsab_resp(fsab_resp),
		.spam_req(spam_req),
		.spam_busy_b(spam_busy_b),
		.spam_data(spam_data)
	);

	tb_fsab_memory #(
		.fsab_did(4'd2),
		.fsab_subdid(4'd3),
		.base_addr(base_addr),
		.initial_credits(int'(dma_pkg::fsab_initial_credits))
	) u_memory (
		.clk(clk),
		.rst_b(rst_b),
		.fsab_req(fsab_req),
		.fsab_credit(fsab_credit),
		.fsab_resp(fsab_resp),
		.error(model_error),
		.req_count(req_count)
	);

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "value check failed");
		end
	endtask

	// One host command, answered in the cycle after it is registered.
	task automatic run_command(input int idx);
		int gap;
		logic [3:0] ctl;
		gap = int'(stim[idx+1]);
		ctl = stim[idx+4][3:0];
		repeat (gap) @(negedge clk);
		if (ctl[2]) begin
			check_value("words fetched and not read", 64'(req_count - pop_count),
				64'(fifo_depth));
		end
		spam_req.valid = ctl[3];
		spam_req.r_nw = ctl[0];
		spam_req.did = stim[idx+2][3:0];
		spam_req.addr = stim[idx+3][23:0];
		@(negedge clk);
		spam_req = '0;
		if (ctl[1]) begin
			check_value("spam_busy_b", 64'(spam_busy_b), 64'(1));
			check_value("spam_data", spam_data, stim[idx+5]);
			last_data = stim[idx+5];
			pop_count++;
		end else begin
			check_value("spam_busy_b", 64'(spam_busy_b), 64'(0));
			check_value("spam_data", spam_data, last_data);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		wait (model_error === 1'b1);
		$display("The FSAB bus model saw a wrong request");
		$display("*** TEST FAILED ***");
		$fatal(1, "bus model check failed");
	end

	initial begin
		#1;
		repeat (cycles_per_cmd * (cmd_total + 1)) @(posedge clk);
		$display("Timeout: the commands did not finish within %0d cycles",
			cycles_per_cmd * (cmd_total + 1));
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst_b = 1'b0;
		spam_req = '0;
		pop_count = 0;
		cmd_total = 0;
		$readmemh("dma_stimulus.txt", stim);
		for (int r = 0; r < rec_max; r++) begin
			if (stim[r*fields] == 64'd0) begin
				break;
			end
			if (stim[r*fields] == 64'd2) begin
				cmd_total++;
			end
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_value("spam_busy_b", 64'(spam_busy_b), 64'(0));
		check_value("fsab_req.valid", 64'(fsab_req.valid), 64'(0));
		rst_b = 1'b1;
		last_data = spam_data;
		for (int r = 0; r < rec_max; r++) begin
			if (stim[r*fields] == 64'd0) begin
				break;
			end
			if (stim[r*fields] == 64'd2) begin
				run_command(r * fields);
			end
		end
		repeat (4) @(negedge clk);
		if (cmd_total > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== dma_stimulus.txt ====
// kind gap did addr ctl word; kind 1 is a response word, kind 2 a SPAM command, kind 0 ends
// ctl bits: 3 valid, 2 check FIFO full, 1 read expected to succeed, 0 r_nw
1 0 0 0 0 0123456789abcdef
1 0 0 0 0 fedcba9876543210
1 0 0 0 0 0000000000000001
1 0 0 0 0 8000000000000000
1 0 0 0 0 deadbeef00c0ffee
1 0 0 0 0 5555aaaa5555aaaa
1 0 0 0 0 00000000ffffffff
1 0 0 0 0 ffffffff00000000
1 0 0 0 0 1357924680acef0d
1 0 0 0 0 0f0f0f0f0f0f0f0f
1 0 0 0 0 a0a1a2a3a4a5a6a7
1 0 0 0 0 1111111111111111
1 0 0 0 0 2222222222222222
1 0 0 0 0 3333333333333333
1 0 0 0 0 4444444444444444
1 0 0 0 0 5555555555555555
1 0 0 0 0 6666666666666666
1 0 0 0 0 7777777777777777
1 0 0 0 0 8888888888888888
1 0 0 0 0 9999999999999999
2 0 5 001000 9 0
2 96 4 001010 d 0
2 0 5 002008 9 0
2 0 5 001000 8 0
2 0 5 001000 b 0123456789abcdef
2 0 5 001008 b fedcba9876543210
2 0 5 001010 b 0000000000000001
2 0 5 001018 b 8000000000000000
2 0 5 001020 b deadbeef00c0ffee
2 0 5 001028 b 5555aaaa5555aaaa
2 0 5 001030 b 00000000ffffffff
2 0 5 001038 b ffffffff00000000
2 3c 5 001040 b 1357924680acef0d
2 0 5 000ff8 9 0
2 3c 5 001ff8 b 0f0f0f0f0f0f0f0f
2 0 5 001100 b a0a1a2a3a4a5a6a7
0 0 0 0 0 0

// ==== filelist.f ====
dma_pkg.sv
dma_read_fifo.sv
dma_fetch_engine.sv
spam_read_port.sv
dma_read_controller.sv
tb_fsab_memory.sv
tb_dma_read_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_dma_read_controller
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) dma_stimulus.txt
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
